/* rvPipe.f */
+incdir+include
source/rvIsaPkg.sv
source/rvPipePkg.sv
source/fetchStage.sv
source/decodeStage.sv
source/executeStage.sv
source/memoryStage.sv
source/rvPipeTop.sv
tests/rvPipeTb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal -Mdir obj_dir
TOP       = rvPipeTb
FILELIST  = rvPipe.f
LOG       = sim.log
PASSTEXT  = Simulation passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	-./obj_dir/$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "$(PASSTEXT)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* tests/rvPipeTb.sv */
// testbench for the pipeline core with a random grouped program and an ISA model
`include "rvPipe_cfg.svh"

module rvPipeTb
    import rvIsaPkg::*;
    import rvPipePkg::*;
;

    localparam int clkPeriod = 10;
    localparam int numGroups = 48;
    localparam int progWords = numGroups * 4;
    localparam int timeoutCycles = progWords * 20 + `RV_IMEM_WORDS + 8 + 4;

    localparam int kindAdd = 0;
    localparam int kindSub = 1;
    localparam int kindAnd = 2;
    localparam int kindOr = 3;
    localparam int kindXor = 4;
    localparam int kindSlt = 5;
    localparam int kindAddi = 6;
    localparam int kindAddi2 = 7;
    localparam int kindLw = 8;
    localparam int kindSw = 9;
    localparam int kindBeq = 10;
    localparam int kindBne = 11;
    localparam int kindUnknown = 12;
    localparam int kindZero = 13;

    logic   clk;
    logic   rst;
    logic   imemWe;
    wordT   imemAddr;
    instrT  imemData;
    logic   retireValid;
    regIdxT retireRd;
    wordT   retireData;
    logic   storeValid;
    wordT   storeAddr;
    wordT   storeValue;

    int    seed = 660;
    instrT prog [progWords];
    int    kindA [numGroups];
    int    rdA [numGroups];
    int    rs1A [numGroups];
    int    rs2A [numGroups];
    int    tgtA [numGroups];
    wordT  immA [numGroups];
    wordT  modelRegs [8];
    wordT  modelMem [`RV_DMEM_WORDS];
    wordT  expRd [$];
    wordT  expData [$];
    wordT  expAddr [$];
    wordT  expVal [$];

    rvPipeTop dut_i (
        .clk         (clk),
        .rst         (rst),
        .imemWe      (imemWe),
        .imemAddr    (imemAddr),
        .imemData    (imemData),
        .retireValid (retireValid),
        .retireRd    (retireRd),
        .retireData  (retireData),
        .storeValid  (storeValid),
        .storeAddr   (storeAddr),
        .storeValue  (storeValue)
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    task automatic stopRun();
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic failRun(string reason);
        $display("error: %s", reason);
        stopRun();
    endtask

    task automatic checkValue(string name, wordT actual, wordT expected);
        if (actual !== expected) begin
            $display("FAILED at time %0t: %s is %h, expected %h",
                     $time, name, actual, expected);
            stopRun();
        end
    endtask

    function automatic int pick(int n);
        pick = int'($unsigned($random(seed)) % n);
    endfunction

    function automatic instrT encodeR(funct7T f7, int rs2, int rs1, funct3T f3, int rd);
        encodeR = {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), opOp};
    endfunction

    function automatic instrT encodeI(wordT imm, int rs1, funct3T f3, int rd, opcodeT op);
        encodeI = {imm[11:0], 5'(rs1), f3, 5'(rd), op};
    endfunction

    function automatic instrT encodeS(wordT imm, int rs2, int rs1);
        encodeS = {imm[11:5], 5'(rs2), 5'(rs1), f3Word, imm[4:0], opStore};
    endfunction

    function automatic instrT encodeB(wordT imm, int rs2, int rs1, funct3T f3);
        encodeB = {imm[12], imm[10:5], 5'(rs2), 5'(rs1), f3, imm[4:1], imm[11], opBranch};
    endfunction

    // one random instruction per group, then three addi x0 nops
    task automatic buildProgram();
        instrT word;
        int    k;
        for (int g = 0; g < numGroups; g++) begin
            k = (g == 0) ? kindAddi : pick(14);
            kindA[g] = k;
            rdA[g] = (g == 0) ? 1 : pick(8);
            rs1A[g] = pick(8);
            rs2A[g] = pick(8);
            immA[g] = wordT'(pick(4096) - 2048);
            tgtA[g] = g + 1 + pick((numGroups - g < 4) ? numGroups - g : 4);
            if (k == kindLw || k == kindSw) begin
                rs1A[g] = 0;
                immA[g] = wordT'(pick(16) * 4);
            end
            if (k == kindBeq || k == kindBne) begin
                immA[g] = wordT'((tgtA[g] - g) * 16);
            end
            case (k)
                kindAdd: word = encodeR(f7Base, rs2A[g], rs1A[g], f3AddSub, rdA[g]);
                kindSub: word = encodeR(f7Sub, rs2A[g], rs1A[g], f3AddSub, rdA[g]);
                kindAnd: word = encodeR(f7Base, rs2A[g], rs1A[g], f3And, rdA[g]);
                kindOr: word = encodeR(f7Base, rs2A[g], rs1A[g], f3Or, rdA[g]);
                kindXor: word = encodeR(f7Base, rs2A[g], rs1A[g], f3Xor, rdA[g]);
                kindSlt: word = encodeR(f7Base, rs2A[g], rs1A[g], f3Slt, rdA[g]);
                kindLw: word = encodeI(immA[g], 0, f3Word, rdA[g], opLoad);
                kindSw: word = encodeS(immA[g], rs2A[g], 0);
                kindBeq: word = encodeB(immA[g], rs2A[g], rs1A[g], f3Beq);
                kindBne: word = encodeB(immA[g], rs2A[g], rs1A[g], f3Bne);
                // custom-0 opcode lies outside the subset
                kindUnknown: word = {immA[g][24:0], 7'b0001011};
                kindZero: word = '0;
                default: word = encodeI(immA[g], rs1A[g], f3AddSub, rdA[g], opOpImm);
            endcase
            prog[g * 4] = word;
            for (int n = 1; n < 4; n++) begin
                prog[g * 4 + n] = encodeI('0, 0, f3AddSub, 0, opOpImm);
            end
        end
    endtask

    task automatic recordRetire(int rd, wordT value);
        if (rd != 0) begin
            modelRegs[rd] = value;
            expRd.push_back(wordT'(rd));
            expData.push_back(value);
        end
    endtask

    // instruction-level model walking the groups from address 0
    task automatic runModel();
        wordT a;
        wordT b;
        wordT addr;
        int   idx;
        int   g;
        int   next;
        for (int r = 0; r < 8; r++) begin
            modelRegs[r] = '0;
        end
        for (int m = 0; m < `RV_DMEM_WORDS; m++) begin
            modelMem[m] = '0;
        end
        g = 0;
        while (g < numGroups) begin
            a = modelRegs[rs1A[g]];
            b = modelRegs[rs2A[g]];
            addr = a + immA[g];
            idx = int'((addr >> 2) % `RV_DMEM_WORDS);
            next = g + 1;
            case (kindA[g])
                kindAdd: recordRetire(rdA[g], a + b);
                kindSub: recordRetire(rdA[g], a - b);
                kindAnd: recordRetire(rdA[g], a & b);
                kindOr: recordRetire(rdA[g], a | b);
                kindXor: recordRetire(rdA[g], a ^ b);
                kindSlt: recordRetire(rdA[g], ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
                kindAddi, kindAddi2: recordRetire(rdA[g], a + immA[g]);
                kindLw: recordRetire(rdA[g], modelMem[idx]);
                kindSw: begin
                    modelMem[idx] = b;
                    expAddr.push_back(addr);
                    expVal.push_back(b);
                end
                kindBeq: if (a == b) next = tgtA[g];
                kindBne: if (a != b) next = tgtA[g];
                default: ;
            endcase
            g = next;
        end
    endtask

    initial begin
        rst = 1'b1;
        imemWe = 1'b0;
        imemAddr = '0;
        imemData = '0;
        buildProgram();
        runModel();
        // whole instruction memory is written so the tail reads zero
        for (int i = 0; i < `RV_IMEM_WORDS; i++) begin
            @(posedge clk);
            #1;
            imemWe = 1'b1;
            imemAddr = wordT'(i * 4);
            imemData = (i < progWords) ? prog[i] : '0;
        end
        @(posedge clk);
        #1;
        imemWe = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        while (expRd.size() != 0 || expAddr.size() != 0) @(posedge clk);
        // idle window for catching extra pulses
        repeat (10) @(posedge clk);
        $display("Simulation passed");
        $finish;
    end

    // outputs are sampled mid-cycle
    always @(negedge clk) begin
        if (rst) begin
            if (retireValid !== 1'b0 || storeValid !== 1'b0) begin
                failRun("retireValid or storeValid was not low while reset was held");
            end
        end else begin
            if ($isunknown({retireValid, storeValid})) begin
                failRun("retireValid or storeValid is unknown after reset");
            end
            if (retireValid) begin
                if (expRd.size() == 0) begin
                    failRun("retire pulse with no retire left in the model");
                end else begin
                    checkValue("retireRd", wordT'(retireRd), expRd[0]);
                    checkValue("retireData", retireData, expData[0]);
                    expRd.delete(0);
                    expData.delete(0);
                end
            end
            if (storeValid) begin
                if (expAddr.size() == 0) begin
                    failRun("store pulse with no store left in the model");
                end else begin
                    checkValue("storeAddr", storeAddr, expAddr[0]);
                    checkValue("storeValue", storeValue, expVal[0]);
                    expAddr.delete(0);
                    expVal.delete(0);
                end
            end
        end
    end

    initial begin
        #(timeoutCycles * clkPeriod);
        failRun("timeout, the DUT did not finish the program in time");
    end

endmodule

/* source/rvPipeTop.sv */
// five-stage RV32I pipeline top with stage registers and writeback select
module rvPipeTop
    import rvIsaPkg::*;
    import rvPipePkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   imemWe,
    input  wordT   imemAddr,
    input  instrT  imemData,
    output logic   retireValid,
    output regIdxT retireRd,
    output wordT   retireData,
    output logic   storeValid,
    output wordT   storeAddr,
    output wordT   storeValue
);

    wordT    fetchPc;
    instrT   fetchInstr;
    wordT    idRs1Val;
    wordT    idRs2Val;
    wordT    idImm;
    regIdxT  idRd;
    aluOpT   idAluOp;
    exCtrlT  idExCtrlD;
    memCtrlT idMemCtrlD;
    wbCtrlT  idWbCtrlD;
    wordT    exAluResult;
    wordT    exTarget;
    logic    exZero;
    wordT    memReadData;
    logic    branchTaken;
    wordT    wbData;

    wordT    ifIdPc;
    instrT   ifIdInstr;

    wordT    idExPc;
    wordT    idExRs1;
    wordT    idExRs2;
    wordT    idExImm;
    aluOpT   idExAluOp;
    regIdxT  idExRd;
    exCtrlT  idExExCtrl;
    memCtrlT idExMemCtrl;
    wbCtrlT  idExWbCtrl;

    wordT    exMemTarget;
    wordT    exMemAlu;
    logic    exMemZero;
    wordT    exMemRs2;
    regIdxT  exMemRd;
    logic    exMemIsBranch;
    memCtrlT exMemMemCtrl;
    wbCtrlT  exMemWbCtrl;

    wordT    memWbReadData;
    wordT    memWbAlu;
    regIdxT  memWbRd;
    wbCtrlT  memWbWbCtrl;

    fetchStage fetch_i (
        .clk          (clk),
        .rst          (rst),
        .branchTaken  (branchTaken),
        .branchTarget (exMemTarget),
        .imemWe       (imemWe),
        .imemAddr     (imemAddr),
        .imemData     (imemData),
        .pc           (fetchPc),
        .instr        (fetchInstr)
    );

    // a zero instruction word is the ifId bubble
    always_ff @(posedge clk) begin
        ifIdPc <= fetchPc;
        if (rst || branchTaken) begin
            ifIdInstr <= '0;
        end else begin
            ifIdInstr <= fetchInstr;
        end
    end

    decodeStage decode_i (
        .clk     (clk),
        .rst     (rst),
        .instr   (ifIdInstr),
        .wbWe    (memWbWbCtrl[wbRegWriteBit]),
        .wbRd    (memWbRd),
        .wbData  (wbData),
        .rs1Val  (idRs1Val),
        .rs2Val  (idRs2Val),
        .imm     (idImm),
        .rd      (idRd),
        .aluOp   (idAluOp),
        .exCtrl  (idExCtrlD),
        .memCtrl (idMemCtrlD),
        .wbCtrl  (idWbCtrlD)
    );

    always_ff @(posedge clk) begin
        idExPc    <= ifIdPc;
        idExRs1   <= idRs1Val;
        idExRs2   <= idRs2Val;
        idExImm   <= idImm;
        idExAluOp <= idAluOp;
        idExRd    <= idRd;
        if (rst || branchTaken) begin
            idExExCtrl  <= '0;
            idExMemCtrl <= '0;
            idExWbCtrl  <= '0;
        end else begin
            idExExCtrl  <= idExCtrlD;
            idExMemCtrl <= idMemCtrlD;
            idExWbCtrl  <= idWbCtrlD;
        end
    end

    executeStage execute_i (
        .pc           (idExPc),
        .rs1Val       (idExRs1),
        .rs2Val       (idExRs2),
        .imm          (idExImm),
        .aluOp        (idExAluOp),
        .exCtrl       (idExExCtrl),
        .aluResult    (exAluResult),
        .branchTarget (exTarget),
        .zero         (exZero)
    );

    // the branch bit rides along so memory can resolve it
    always_ff @(posedge clk) begin
        exMemTarget <= exTarget;
        exMemAlu    <= exAluResult;
        exMemZero   <= exZero;
        exMemRs2    <= idExRs2;
        exMemRd     <= idExRd;
        if (rst || branchTaken) begin
            exMemIsBranch <= 1'b0;
            exMemMemCtrl  <= '0;
            exMemWbCtrl   <= '0;
        end else begin
            exMemIsBranch <= idExExCtrl[exBranchBit];
            exMemMemCtrl  <= idExMemCtrl;
            exMemWbCtrl   <= idExWbCtrl;
        end
    end

    memoryStage memory_i (
        .clk         (clk),
        .rst         (rst),
        .memCtrl     (exMemMemCtrl),
        .isBranch    (exMemIsBranch),
        .zero        (exMemZero),
        .aluResult   (exMemAlu),
        .storeData   (exMemRs2),
        .readData    (memReadData),
        .branchTaken (branchTaken),
        .storeValid  (storeValid),
        .storeAddr   (storeAddr),
        .storeValue  (storeValue)
    );

    always_ff @(posedge clk) begin
        memWbReadData <= memReadData;
        memWbAlu      <= exMemAlu;
        memWbRd       <= exMemRd;
        if (rst) begin
            memWbWbCtrl <= '0;
        end else begin
            memWbWbCtrl <= exMemWbCtrl;
        end
    end

    // writeback select
    assign wbData = memWbWbCtrl[wbMemToRegBit] ? memWbReadData : memWbAlu;

    // x0 writes stay invisible
    assign retireValid = memWbWbCtrl[wbRegWriteBit] && (memWbRd != '0);
    assign retireRd    = memWbRd;
    assign retireData  = wbData;

endmodule

/* source/memoryStage.sv */
// memory stage: data memory, branch decision and store report port
`include "rvPipe_cfg.svh"

module memoryStage
    import rvIsaPkg::*;
    import rvPipePkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  memCtrlT memCtrl,
    input  logic    isBranch,
    input  logic    zero,
    input  wordT    aluResult,
    input  wordT    storeData,
    output wordT    readData,
    output logic    branchTaken,
    output logic    storeValid,
    output wordT    storeAddr,
    output wordT    storeValue
);

    localparam int dmemAw = $clog2(`RV_DMEM_WORDS);

    wordT dmem [`RV_DMEM_WORDS];
    logic [dmemAw-1:0] wordIdx;

    // word address modulo the memory depth
    assign wordIdx = aluResult[dmemAw+1:2];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `RV_DMEM_WORDS; i++) begin
                dmem[i] <= '0;
            end
        end else if (memCtrl[memWriteBit]) begin
            dmem[wordIdx] <= storeData;
        end
    end

    assign readData = memCtrl[memReadBit] ? dmem[wordIdx] : '0;

    // beq on zero, bne on nonzero
    assign branchTaken = isBranch && (memCtrl[memBneBit] ? !zero : zero);

    assign storeValid = memCtrl[memWriteBit];
    assign storeAddr  = aluResult;
    assign storeValue = storeData;

endmodule

/* source/executeStage.sv */
// execute stage: operand select, ALU and branch target adder
module executeStage
    import rvIsaPkg::*;
    import rvPipePkg::*;
(
    input  wordT   pc,
    input  wordT   rs1Val,
    input  wordT   rs2Val,
    input  wordT   imm,
    input  aluOpT  aluOp,
    input  exCtrlT exCtrl,
    output wordT   aluResult,
    output wordT   branchTarget,
    output logic   zero
);

    wordT opA;
    wordT opB;

    assign opA = rs1Val;
    assign opB = exCtrl[exUseImmBit] ? imm : rs2Val;

    always_comb begin
        case (aluOp)
            aluAdd:
                aluResult = opA + opB;
            aluSub:
                aluResult = opA - opB;
            aluAnd:
                aluResult = opA & opB;
            aluOr:
                aluResult = opA | opB;
            aluXor:
                aluResult = opA ^ opB;
            aluSlt:
                // signed compare
                aluResult = ($signed(opA) < $signed(opB)) ? wordT'(1) : '0;
            default:
                aluResult = '0;
        endcase
    end

    // for a branch the sub result is zero exactly when operands match
    assign zero = (aluResult == '0);

    assign branchTarget = pc + imm;

endmodule

/* source/decodeStage.sv */
// decode stage: field split, immediate build, control decode, register file
`include "rvPipe_cfg.svh"

module decodeStage
    import rvIsaPkg::*;
    import rvPipePkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  instrT   instr,
    input  logic    wbWe,
    input  regIdxT  wbRd,
    input  wordT    wbData,
    output wordT    rs1Val,
    output wordT    rs2Val,
    output wordT    imm,
    output regIdxT  rd,
    output aluOpT   aluOp,
    output exCtrlT  exCtrl,
    output memCtrlT memCtrl,
    output wbCtrlT  wbCtrl
);

    wordT   regs [`RV_NUM_REGS];
    opcodeT opcode;
    funct3T funct3;
    funct7T funct7;
    regIdxT rs1;
    regIdxT rs2;

    assign opcode = instr[6:0];
    assign rd     = instr[11:7];
    assign funct3 = instr[14:12];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign funct7 = instr[31:25];

    // immediate format follows the opcode
    always_comb begin
        case (opcode)
            opStore:
                imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            opBranch:
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
            default:
                imm = {{20{instr[31]}}, instr[31:20]};
        endcase
    end

    // anything outside the subset leaves all control at zero
    always_comb begin
        aluOp   = aluAdd;
        exCtrl  = '0;
        memCtrl = '0;
        wbCtrl  = '0;
        case (opcode)
            opOp: begin
                wbCtrl[wbRegWriteBit] = 1'b1;
                if (funct3 == f3AddSub && funct7 == f7Sub) begin
                    aluOp = aluSub;
                end else if (funct7 != f7Base) begin
                    wbCtrl = '0;
                end else begin
                    case (funct3)
                        f3AddSub: aluOp = aluAdd;
                        f3Slt:    aluOp = aluSlt;
                        f3Xor:    aluOp = aluXor;
                        f3Or:     aluOp = aluOr;
                        f3And:    aluOp = aluAnd;
                        default:  wbCtrl = '0;
                    endcase
                end
            end
            opOpImm: begin
                if (funct3 == f3AddSub) begin
                    exCtrl[exUseImmBit]   = 1'b1;
                    wbCtrl[wbRegWriteBit] = 1'b1;
                end
            end
            opLoad: begin
                if (funct3 == f3Word) begin
                    exCtrl[exUseImmBit]   = 1'b1;
                    memCtrl[memReadBit]   = 1'b1;
                    wbCtrl[wbRegWriteBit] = 1'b1;
                    wbCtrl[wbMemToRegBit] = 1'b1;
                end
            end
            opStore: begin
                if (funct3 == f3Word) begin
                    exCtrl[exUseImmBit]  = 1'b1;
                    memCtrl[memWriteBit] = 1'b1;
                end
            end
            opBranch: begin
                // compare by subtraction, zero flag decides in memory
                if (funct3 == f3Beq || funct3 == f3Bne) begin
                    aluOp                = aluSub;
                    exCtrl[exBranchBit]  = 1'b1;
                    memCtrl[memBneBit]   = (funct3 == f3Bne);
                end
            end
            default: ;
        endcase
    end

    // register file, x0 is never written
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `RV_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wbWe && wbRd != '0) begin
            regs[wbRd] <= wbData;
        end
    end

    // no write-through, producer must be four instructions ahead
    assign rs1Val = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2Val = (rs2 == '0) ? '0 : regs[rs2];

endmodule

/* source/fetchStage.sv */
// fetch stage: program counter and instruction memory with a load port
`include "rvPipe_cfg.svh"

module fetchStage
    import rvIsaPkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  branchTaken,
    input  wordT  branchTarget,
    input  logic  imemWe,
    input  wordT  imemAddr,
    input  instrT imemData,
    output wordT  pc,
    output instrT instr
);

    localparam int imemAw = $clog2(`RV_IMEM_WORDS);

    instrT imem [`RV_IMEM_WORDS];

    // pc steps one word per cycle unless a branch in memory redirects it
    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
        end else if (branchTaken) begin
            pc <= branchTarget;
        end else begin
            pc <= pc + wordT'(4);
        end
    end

    // load port takes a byte address, low two bits ignored
    always_ff @(posedge clk) begin
        if (imemWe) begin
            imem[imemAddr[imemAw+1:2]] <= imemData;
        end
    end

    // addresses past the array wrap around
    assign instr = imem[pc[imemAw+1:2]];

endmodule

/* source/rvPipePkg.sv */
// pipeline control types: ALU operation and per-stage control vectors
package rvPipePkg;

    typedef enum logic [2:0] {
        aluAdd = 3'd0,
        aluSub = 3'd1,
        aluAnd = 3'd2,
        aluOr  = 3'd3,
        aluXor = 3'd4,
        aluSlt = 3'd5
    } aluOpT;

    // execute control: {useImm, isBranch}
    typedef logic [1:0] exCtrlT;
    localparam int exUseImmBit = 1;
    localparam int exBranchBit = 0;

    // memory control: {memRead, memWrite, bne}
    typedef logic [2:0] memCtrlT;
    localparam int memReadBit  = 2;
    localparam int memWriteBit = 1;
    localparam int memBneBit   = 0;

    // writeback control: {regWrite, memToReg}
    typedef logic [1:0] wbCtrlT;
    localparam int wbRegWriteBit = 1;
    localparam int wbMemToRegBit = 0;

endpackage

/* source/rvIsaPkg.sv */
// instruction set types and encodings for the supported RV32I subset
`include "rvPipe_cfg.svh"

package rvIsaPkg;

    typedef logic [`RV_XLEN-1:0] wordT;
    typedef logic [31:0] instrT;
    typedef logic [$clog2(`RV_NUM_REGS)-1:0] regIdxT;

    typedef logic [6:0] opcodeT;
    typedef logic [2:0] funct3T;
    typedef logic [6:0] funct7T;

    // major opcodes
    localparam opcodeT opOp     = 7'b0110011;
    localparam opcodeT opOpImm  = 7'b0010011;
    localparam opcodeT opLoad   = 7'b0000011;
    localparam opcodeT opStore  = 7'b0100011;
    localparam opcodeT opBranch = 7'b1100011;

    // funct3 for ALU ops, addi shares f3AddSub
    localparam funct3T f3AddSub = 3'b000;
    localparam funct3T f3Slt    = 3'b010;
    localparam funct3T f3Xor    = 3'b100;
    localparam funct3T f3Or     = 3'b110;
    localparam funct3T f3And    = 3'b111;

    // word access for lw and sw
    localparam funct3T f3Word   = 3'b010;

    localparam funct3T f3Beq    = 3'b000;
    localparam funct3T f3Bne    = 3'b001;

    // funct7 separates add from sub
    localparam funct7T f7Base   = 7'b0000000;
    localparam funct7T f7Sub    = 7'b0100000;

endpackage

/* include/rvPipe_cfg.svh */
// sizing macros for the five-stage RV32I pipeline core
`ifndef RVPIPE_CFG_SVH
`define RVPIPE_CFG_SVH

// data and address width
`define RV_XLEN 32

// memory depths in 32-bit words
`define RV_IMEM_WORDS 256
`define RV_DMEM_WORDS 64

`define RV_NUM_REGS 32

`endif
